//--- src/ecc_sram_settings.svh
// ==========================================================================
// Build-time settings of the ECC SRAM bank
// ECC_BANK_WORDS should be a power of two, the word address is its clog2
// Bus addresses are byte addresses, word select starts at ECC_ADDR_LSB
// The scrubber only uses cycles without a bus request to the bank
// ==========================================================================
`ifndef ECC_SRAM_SETTINGS_SVH
`define ECC_SRAM_SETTINGS_SVH

// Number of 39-bit codewords held by the bank
`define ECC_BANK_WORDS 64

// First byte-address bit of the word address (32-bit words)
`define ECC_ADDR_LSB 2

`endif

//--- src/ecc_code_pkg.sv
// ==========================================================================
// SECDED 39/32 code with a Hsiao check matrix of weight-3 columns
// Corrects one flipped bit and detects two, three or more go undetected
// Check bits sit in codeword bits 38:32 above the data
// ==========================================================================
`default_nettype none

package ecc_code_pkg;

  typedef logic [38:0] codeword_t;
  typedef logic [6:0]  syndrome_t;

  typedef struct packed {
    logic [31:0] data;       // Corrected data
    syndrome_t   syndrome;
    logic        single_err; // Corrected error
    logic        multi_err;  // Uncorrectable error
  } decode_t;

  typedef syndrome_t [31:0] hsiao_cols_t;

  // First 32 distinct 7-bit columns of weight three
  function automatic hsiao_cols_t hsiao_columns();
    hsiao_cols_t cols;
    logic [6:0]  col;
    int unsigned n;
    cols = '0;
    n    = 0;
    for (int v = 0; v < 128; v++) begin
      col = 7'(v);
      if ($countones(col) == 3 && n < 32) begin
        cols[n] = col;
        n++;
      end
    end
    return cols;
  endfunction

  localparam hsiao_cols_t HsiaoCols = hsiao_columns();

  function automatic codeword_t secded_encode(logic [31:0] data);
    syndrome_t chk;
    chk = '0;
    for (int i = 0; i < 32; i++) begin
      if (data[i]) chk ^= HsiaoCols[i];
    end
    return {chk, data};
  endfunction

  function automatic decode_t secded_decode(codeword_t cw);
    decode_t   res;
    syndrome_t syn;
    syn = cw[38:32];
    for (int i = 0; i < 32; i++) begin
      if (cw[i]) syn ^= HsiaoCols[i];
    end
    res.data = cw[31:0];
    // Flip the data bit whose column matches the syndrome
    for (int i = 0; i < 32; i++) begin
      if (syn == HsiaoCols[i]) res.data[i] = ~cw[i];
    end
    res.syndrome   = syn;
    res.single_err = ^syn;                      // Odd weight, one bit flipped
    res.multi_err  = (syn != '0) && !(^syn);    // Even weight, two bits
    return res;
  endfunction

endpackage

`default_nettype wire

//--- src/tcdm_pkg.sv
// ==========================================================================
// Types of the 32-bit request/grant data bus and of the bank word address
// Bank address width follows ECC_BANK_WORDS from the settings header
// ==========================================================================
`default_nettype none

`include "ecc_sram_settings.svh"

package tcdm_pkg;

  typedef logic [31:0] tcdm_addr_t; // Byte address
  typedef logic [31:0] tcdm_data_t;
  typedef logic [3:0]  tcdm_be_t;

  localparam int unsigned BankAddrWidth = $clog2(`ECC_BANK_WORDS);

  typedef logic [BankAddrWidth-1:0] bank_addr_t; // Word address

  localparam tcdm_be_t BeFull = 4'b1111;

endpackage

`default_nettype wire

//--- src/bank_if.sv
// ==========================================================================
// Bank request channel, single port with plain req and we strobes
// A request is performed at the edge ending its cycle
// Read data shows one cycle later and holds until the next read
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

interface bank_if;
  import ecc_code_pkg::*;
  import tcdm_pkg::*;

  logic       req;
  logic       we;    // High for a write
  bank_addr_t addr;
  codeword_t  wdata;
  codeword_t  rdata;

  modport requester (
    output req, we, addr, wdata,
    input  rdata
  );

  modport memory (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

//--- src/ecc_store_adapter.sv
// ==========================================================================
// Bus to bank adapter with SECDED encode and decode
// Partial stores become a read-modify-write, grant drops for one cycle
// Load data and error flags are valid the cycle after the grant
// The fault mask flips codeword bits of every store it comes with
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ecc_sram_settings.svh"

module ecc_store_adapter (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     req_i,
  input  wire logic                     wen_i,        // High for load
  input  wire tcdm_pkg::tcdm_addr_t     addr_i,
  input  wire tcdm_pkg::tcdm_data_t     wdata_i,
  input  wire tcdm_pkg::tcdm_be_t       be_i,
  input  wire ecc_code_pkg::codeword_t  fault_mask_i,
  output logic                          gnt_o,
  output tcdm_pkg::tcdm_data_t          rdata_o,
  output logic                          single_error_o,
  output logic                          multi_error_o,
  bank_if.requester                     bank_o
);
  import ecc_code_pkg::*;
  import tcdm_pkg::*;

  typedef enum logic {NORMAL, MERGE} state_e;

  state_e     state_q, state_d;
  bank_addr_t addr_q;
  tcdm_data_t wdata_q;
  tcdm_be_t   be_q;
  codeword_t  mask_q;
  logic       rvalid_q;

  decode_t    dec;
  bank_addr_t req_addr;
  tcdm_data_t be_bits;
  tcdm_data_t merged;
  tcdm_data_t store_data;
  codeword_t  store_mask;
  logic       partial_st;

  assign req_addr   = addr_i[`ECC_ADDR_LSB +: BankAddrWidth];
  assign partial_st = req_i && !wen_i && (be_i != BeFull);
  assign dec        = secded_decode(bank_o.rdata);

  // Old bytes from the corrected bank word, new bytes from the buffer
  assign be_bits = {{8{be_q[3]}}, {8{be_q[2]}}, {8{be_q[1]}}, {8{be_q[0]}}};
  assign merged  = (wdata_q & be_bits) | (dec.data & ~be_bits);

  assign store_data = (state_q == MERGE) ? merged : wdata_i;
  assign store_mask = (state_q == MERGE) ? mask_q : fault_mask_i;

  assign rdata_o        = dec.data;
  assign single_error_o = rvalid_q && dec.single_err;
  assign multi_error_o  = rvalid_q && dec.multi_err;

  always_comb begin
    state_d      = NORMAL;
    gnt_o        = 1'b1;
    bank_o.req   = req_i;
    bank_o.we    = !wen_i;
    bank_o.addr  = req_addr;
    bank_o.wdata = secded_encode(store_data) ^ store_mask;
    if (state_q == MERGE) begin
      gnt_o       = 1'b0;    // Write-back cycle owns the bank
      bank_o.req  = 1'b1;
      bank_o.we   = 1'b1;
      bank_o.addr = addr_q;
    end else if (partial_st) begin
      state_d   = MERGE;
      bank_o.we = 1'b0;      // Read the old word first
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= NORMAL;
      rvalid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= req_i && gnt_o && (wen_i || (be_i != BeFull));
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      addr_q  <= req_addr;
      wdata_q <= wdata_i;
      be_q    <= be_i;
      mask_q  <= fault_mask_i;
    end
  end

  a_gnt_single_gap: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !gnt_o |=> gnt_o
  );

endmodule

`default_nettype wire

//--- src/ecc_scrubber.sv
// ==========================================================================
// Background scrubber between the bus adapter and the bank
// Bus requests always win, scrub accesses only use cycles without one
// A single error is written back corrected, multi errors are only reported
// A bus write to the pending word drops the write-back and forces a re-read
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ecc_sram_settings.svh"

module ecc_scrubber (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  scrub_trigger_i,     // Level, scrubs while high
  output logic       scrubber_fix_o,
  output logic       scrub_uncorrectable_o,
  bank_if.memory     intc_i,
  bank_if.requester  bank_o
);
  import ecc_code_pkg::*;
  import tcdm_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, CHECK, FIX} scrub_state_e;

  scrub_state_e state_q, state_d;
  bank_addr_t   scrub_addr_q, scrub_addr_d;
  codeword_t    fix_word_q;

  decode_t dec;
  logic    bus_idle;
  logic    bus_hit;
  logic    scrub_req;
  logic    scrub_we;
  logic    advance;

  assign dec      = secded_decode(bank_o.rdata);
  assign bus_idle = !intc_i.req;
  assign bus_hit  = intc_i.req && intc_i.we && (intc_i.addr == scrub_addr_q);

  // Bank mux, bus first
  assign bank_o.req   = intc_i.req || scrub_req;
  assign bank_o.we    = intc_i.req ? intc_i.we : scrub_we;
  assign bank_o.addr  = intc_i.req ? intc_i.addr : scrub_addr_q;
  assign bank_o.wdata = intc_i.req ? intc_i.wdata : fix_word_q;
  assign intc_i.rdata = bank_o.rdata;

  always_comb begin
    state_d               = state_q;
    scrub_req             = 1'b0;
    scrub_we              = 1'b0;
    advance               = 1'b0;
    scrubber_fix_o        = 1'b0;
    scrub_uncorrectable_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (scrub_trigger_i) state_d = READ;
      end
      READ: begin
        if (!scrub_trigger_i) begin
          state_d = IDLE;
        end else if (bus_idle) begin
          scrub_req = 1'b1;
          state_d   = CHECK;
        end
      end
      CHECK: begin
        state_d = scrub_trigger_i ? READ : IDLE;
        if (dec.multi_err) begin
          scrub_uncorrectable_o = 1'b1;
          advance               = 1'b1;
        end else if (dec.single_err) begin
          if (scrub_trigger_i && !bus_hit) state_d = FIX; // Else re-read
        end else begin
          advance = 1'b1;
        end
      end
      FIX: begin
        if (!scrub_trigger_i) begin
          state_d = IDLE;
        end else if (bus_hit) begin
          state_d = READ;            // Word changed under us
        end else if (bus_idle) begin
          scrub_req      = 1'b1;
          scrub_we       = 1'b1;
          scrubber_fix_o = 1'b1;
          advance        = 1'b1;
          state_d        = READ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    scrub_addr_d = scrub_addr_q;
    if (advance) begin
      if (scrub_addr_q == bank_addr_t'(`ECC_BANK_WORDS - 1)) scrub_addr_d = '0;
      else scrub_addr_d = scrub_addr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      scrub_addr_q <= '0;
    end else begin
      state_q      <= state_d;
      scrub_addr_q <= scrub_addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == CHECK) fix_word_q <= secded_encode(dec.data); // Clean copy
  end

  a_bus_priority: assert property (
    @(posedge clk_i) disable iff (!rst_ni) intc_i.req |-> !scrub_req
  );

endmodule

`default_nettype wire

//--- src/sram_bank.sv
// ==========================================================================
// Single-port codeword array with one cycle read latency
// Contents are undefined after reset, only the read register clears
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ecc_sram_settings.svh"

module sram_bank (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  bank_if.memory    mem_i
);
  import ecc_code_pkg::*;

  codeword_t mem_q [`ECC_BANK_WORDS];
  codeword_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem_i.req && mem_i.we) mem_q[mem_i.addr] <= mem_i.wdata;
  end

  // Holds the last read until the next one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (mem_i.req && !mem_i.we) begin
      rdata_q <= mem_q[mem_i.addr];
    end
  end

  assign mem_i.rdata = rdata_q;

  a_addr_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_i.req |-> !$isunknown(mem_i.addr)
  );

endmodule

`default_nettype wire

//--- src/ecc_sram_top.sv
// ==========================================================================
// ECC protected data memory bank with background scrubber
// Requesters hold req and data until granted, grant drops after partials
// Tie fault_mask_i to zero in normal operation
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module ecc_sram_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     scrub_trigger_i,
  input  wire logic                     req_i,
  input  wire logic                     wen_i,
  input  wire tcdm_pkg::tcdm_addr_t     addr_i,
  input  wire tcdm_pkg::tcdm_data_t     wdata_i,
  input  wire tcdm_pkg::tcdm_be_t       be_i,
  input  wire ecc_code_pkg::codeword_t  fault_mask_i,
  output logic                          gnt_o,
  output tcdm_pkg::tcdm_data_t          rdata_o,
  output logic                          single_error_o,
  output logic                          multi_error_o,
  output logic                          scrubber_fix_o,
  output logic                          scrub_uncorrectable_o
);

  bank_if intc_bus (); // Adapter to scrubber
  bank_if bank_bus (); // Scrubber to bank

  ecc_store_adapter i_store_adapter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .wen_i          (wen_i),
    .addr_i         (addr_i),
    .wdata_i        (wdata_i),
    .be_i           (be_i),
    .fault_mask_i   (fault_mask_i),
    .gnt_o          (gnt_o),
    .rdata_o        (rdata_o),
    .single_error_o (single_error_o),
    .multi_error_o  (multi_error_o),
    .bank_o         (intc_bus.requester)
  );

  ecc_scrubber i_scrubber (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .scrub_trigger_i       (scrub_trigger_i),
    .scrubber_fix_o        (scrubber_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o),
    .intc_i                (intc_bus.memory),
    .bank_o                (bank_bus.requester)
  );

  sram_bank i_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem_i  (bank_bus.memory)
  );

endmodule

`default_nettype wire

//--- verification/tb_ecc_sram.sv
// ==========================================================================
// Testbench for the ECC SRAM bank, random stimulus from a fixed seed
// A reference model keeps data and flipped-bit count per word
// Every word is written before it is read, bank contents start undefined
// Scrubber results are checked as pulse counts over whole sweeps
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "ecc_sram_settings.svh"

module tb_ecc_sram;
  import ecc_code_pkg::*;
  import tcdm_pkg::*;

  localparam int Words       = `ECC_BANK_WORDS;
  localparam int NumOps      = 744;                 // Bus operations over all phases
  localparam int ScrubCycles = 2 * Words * 3 + 8;   // Two sweeps with fixes
  localparam int WatchdogNs  = (NumOps * 4 + Words * 3 * 4) * 4 + 1000;

  logic       clk_i;
  logic       rst_ni;
  logic       scrub_trigger_i;
  logic       req_i;
  logic       wen_i;
  tcdm_addr_t addr_i;
  tcdm_data_t wdata_i;
  tcdm_be_t   be_i;
  codeword_t  fault_mask_i;
  logic       gnt_o;
  tcdm_data_t rdata_o;
  logic       single_error_o;
  logic       multi_error_o;
  logic       scrubber_fix_o;
  logic       scrub_uncorrectable_o;

  // Reference model
  tcdm_data_t model_data  [Words];
  int         model_flips [Words];

  // Monitor state
  logic       checking     = 1'b0;
  logic       partial_prev = 1'b0;
  logic       pend_valid   = 1'b0;
  logic       pend_load    = 1'b0;
  tcdm_data_t pend_data;
  int         pend_flips;
  int         mon_word;
  logic       accepted;
  logic       exp_single;
  logic       exp_multi;
  tcdm_data_t be_mask;
  int         errors       = 0;
  int         checks       = 0;
  int         fix_pulses   = 0;
  int         unc_pulses   = 0;

  ecc_sram_top i_ecc_sram_top (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .scrub_trigger_i       (scrub_trigger_i),
    .req_i                 (req_i),
    .wen_i                 (wen_i),
    .addr_i                (addr_i),
    .wdata_i               (wdata_i),
    .be_i                  (be_i),
    .fault_mask_i          (fault_mask_i),
    .gnt_o                 (gnt_o),
    .rdata_o               (rdata_o),
    .single_error_o        (single_error_o),
    .multi_error_o         (multi_error_o),
    .scrubber_fix_o        (scrubber_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic tcdm_data_t byte_bits(tcdm_be_t be);
    tcdm_data_t bits;
    for (int b = 0; b < 4; b++) begin
      bits[8*b +: 8] = {8{be[b]}};
    end
    return bits;
  endfunction

  function automatic int random_word();
    return int'($urandom % Words);
  endfunction

  function automatic codeword_t one_flip_mask();
    codeword_t m;
    m = '0;
    m[$urandom % 39] = 1'b1;
    return m;
  endfunction

  function automatic codeword_t two_flip_mask();
    codeword_t   m;
    int unsigned p0;
    int unsigned p1;
    p0 = $urandom % 39;
    p1 = (p0 + 1 + ($urandom % 38)) % 39; // Always a second position
    m = '0;
    m[p0] = 1'b1;
    m[p1] = 1'b1;
    return m;
  endfunction

  // Starts 1 ns after a rising edge, returns at the same point after the grant
  task automatic bus_access(input logic load, input int word, input tcdm_data_t data,
                            input tcdm_be_t be, input codeword_t mask);
    req_i        = 1'b1;
    wen_i        = load;
    addr_i       = tcdm_addr_t'(word) << `ECC_ADDR_LSB;
    wdata_i      = data;
    be_i         = be;
    fault_mask_i = mask;
    @(negedge clk_i);
    while (!gnt_o) begin
      @(posedge clk_i);
      #1;
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic partial_store(input int word, input codeword_t mask);
    bus_access(1'b0, word, $urandom, tcdm_be_t'($urandom % 15), mask);
  endtask

  // Checks grant and load responses, then updates the model on acceptance
  always @(negedge clk_i) begin
    if (checking) begin
      checks++;
      if (gnt_o !== !partial_prev) begin
        errors++;
        $display("** Error at %0t: gnt_o is %b, expected %b", $time, gnt_o, !partial_prev);
      end
      exp_single = pend_valid && (pend_flips == 1);
      exp_multi  = pend_valid && (pend_flips == 2);
      if (single_error_o !== exp_single || multi_error_o !== exp_multi) begin
        errors++;
        $display("** Error at %0t: flags single %b multi %b, expected %b %b", $time,
                 single_error_o, multi_error_o, exp_single, exp_multi);
      end
      if (pend_load && pend_flips < 2 && rdata_o !== pend_data) begin
        errors++;
        $display("** Error at %0t: load returned %h, expected %h", $time, rdata_o, pend_data);
      end
      if (scrubber_fix_o) fix_pulses++;
      if (scrub_uncorrectable_o) unc_pulses++;
      accepted     = req_i && gnt_o;
      partial_prev = accepted && !wen_i && (be_i != 4'hf);
      pend_valid   = accepted && (wen_i || (be_i != 4'hf));
      pend_load    = accepted && wen_i;
      if (accepted) begin
        mon_word   = int'(addr_i >> `ECC_ADDR_LSB) % Words;
        pend_data  = model_data[mon_word];
        pend_flips = model_flips[mon_word];
        if (!wen_i) begin
          be_mask                = byte_bits(be_i);
          model_data[mon_word]   = (wdata_i & be_mask) | (model_data[mon_word] & ~be_mask);
          model_flips[mon_word]  = $countones(fault_mask_i);
        end
      end
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns before the tests finished", WatchdogNs);
    $display("Something failed");
    $finish;
  end

  initial begin
    int word;
    int kind;
    int n_single;
    int n_double;
    int fix_start;
    int unc_start;
    int single_words[$];
    void'($urandom(32'hd56c));
    rst_ni          = 1'b0;
    scrub_trigger_i = 1'b0;
    req_i           = 1'b0;
    wen_i           = 1'b1;
    addr_i          = '0;
    wdata_i         = '0;
    be_i            = 4'hf;
    fault_mask_i    = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    checking = 1'b1;
    idle_cycles(2);

    // Clean full stores to every word, then random loads
    for (int w = 0; w < Words; w++) bus_access(1'b0, w, $urandom, 4'hf, '0);
    repeat (100) bus_access(1'b1, random_word(), '0, 4'hf, '0);

    // Partial stores, some with a single flipped bit, each read back
    repeat (60) begin
      word = random_word();
      if ($urandom % 2) partial_store(word, one_flip_mask());
      else partial_store(word, '0);
      bus_access(1'b1, word, '0, 4'hf, '0);
    end

    // Injected single and double errors
    repeat (10) begin
      word = random_word();
      bus_access(1'b0, word, $urandom, 4'hf, one_flip_mask());
      bus_access(1'b1, word, '0, 4'hf, '0);
    end
    repeat (6) begin
      word = random_word();
      bus_access(1'b0, word, $urandom, 4'hf, two_flip_mask());
      bus_access(1'b1, word, '0, 4'hf, '0);
    end

    // Two scrub sweeps with the bus idle
    n_single = 0;
    n_double = 0;
    for (int w = 0; w < Words; w++) begin
      if (model_flips[w] == 1) n_single++;
      if (model_flips[w] == 2) n_double++;
    end
    fix_start       = fix_pulses;
    unc_start       = unc_pulses;
    scrub_trigger_i = 1'b1;
    idle_cycles(ScrubCycles);
    scrub_trigger_i = 1'b0;
    idle_cycles(4);
    if (fix_pulses - fix_start != n_single) begin
      errors++;
      $display("** Error at %0t: %0d scrub fixes, expected %0d", $time,
               fix_pulses - fix_start, n_single);
    end
    if (unc_pulses - unc_start < n_double) begin
      errors++;
      $display("** Error at %0t: %0d uncorrectable reports, expected at least %0d", $time,
               unc_pulses - unc_start, n_double);
    end
    for (int w = 0; w < Words; w++) begin
      if (model_flips[w] == 1) begin
        model_flips[w] = 0;   // Rewritten by the scrubber
        single_words.push_back(w);
      end
    end
    foreach (single_words[i]) bus_access(1'b1, single_words[i], '0, 4'hf, '0);

    // Clean bank, then bus traffic mixed with scrubbing
    for (int w = 0; w < Words; w++) bus_access(1'b0, w, $urandom, 4'hf, '0);
    fix_start       = fix_pulses;
    unc_start       = unc_pulses;
    scrub_trigger_i = 1'b1;
    repeat (300) begin
      kind = int'($urandom % 4);
      word = random_word();
      if (kind < 2) bus_access(1'b1, word, '0, 4'hf, '0);
      else if (kind == 2) bus_access(1'b0, word, $urandom, 4'hf, '0);
      else partial_store(word, '0);
      idle_cycles(int'($urandom % 3));
    end
    scrub_trigger_i = 1'b0;
    idle_cycles(4);
    if (fix_pulses != fix_start || unc_pulses != unc_start) begin
      errors++;
      $display("** Error at %0t: scrubber reported errors on a clean bank", $time);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+src
src/ecc_code_pkg.sv
src/tcdm_pkg.sv
src/bank_if.sv
src/ecc_store_adapter.sv
src/ecc_scrubber.sv
src/sram_bank.sv
src/ecc_sram_top.sv
verification/tb_ecc_sram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the ECC SRAM testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f vlog.f \
  --top-module tb_ecc_sram \
  -Mdir obj_dir

output="$(./obj_dir/Vtb_ecc_sram)"
echo "$output"

if grep -qx "Everything OK" <<< "$output"; then
  exit 0
else
  exit 1
fi
